// File: verilog/rvMemPkg.sv
`default_nettype none

package rvMemPkg;

    localparam int xlen = 64;
    localparam int maskWidth = xlen / 8;

    // funct3 of loads and stores
    typedef logic [2:0] widthCode;

    localparam widthCode lb  = 3'b000;
    localparam widthCode lh  = 3'b001;
    localparam widthCode lw  = 3'b010;
    localparam widthCode ld  = 3'b011;
    localparam widthCode lbu = 3'b100;
    localparam widthCode lhu = 3'b101;
    localparam widthCode lwu = 3'b110;

    // one memory word seen by lane size
    typedef union packed {
        logic [xlen-1:0] dword;
        logic [1:0][31:0] word;
        logic [3:0][15:0] half;
        logic [7:0][7:0] bytes;
    } memWord;

endpackage

`default_nettype wire

// File: verilog/platformPkg.sv
`default_nettype none

package platformPkg;

    // CLINT style timer registers
    localparam logic [rvMemPkg::xlen-1:0] mtimecmpAddr = 64'h0000_0000_0200_4000;
    localparam logic [rvMemPkg::xlen-1:0] mtimeAddr = 64'h0000_0000_0200_bff8;

    // no interrupt until software programs a compare value
    localparam logic [rvMemPkg::xlen-1:0] mtimecmpReset = '1;

endpackage

`default_nettype wire

// File: verilog/memReqIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memReqIf;

    logic reqWrite;
    rvMemPkg::widthCode reqWidth;
    logic [rvMemPkg::xlen-1:0] reqAddr;
    logic [rvMemPkg::xlen-1:0] reqWdata;

    // single cycle strobes from the access FSM
    logic captureLoad;
    logic timerWrite;

    modport ctrl (
        output reqWrite, reqWidth, reqAddr, reqWdata,
        output captureLoad, timerWrite
    );

    modport data (
        input reqWrite, reqWidth, reqAddr, reqWdata,
        input captureLoad, timerWrite
    );

endinterface

`default_nettype wire

// File: verilog/accessControl.sv
`timescale 1ns/1ps
`default_nettype none

module accessControl (
    input  logic clk,
    input  logic arstN,
    input  logic reqValid,
    input  logic reqWrite,
    input  rvMemPkg::widthCode reqWidth,
    input  logic [rvMemPkg::xlen-1:0] reqAddr,
    input  logic [rvMemPkg::xlen-1:0] reqWdata,
    input  logic memStall,
    output logic busy,
    output logic done,
    output logic weMem,
    output logic reMem,
    memReqIf.ctrl req
);

    typedef enum logic [1:0] {
        stateIdle,
        stateAccess,
        stateDone
    } ctrlState;

    ctrlState state;
    ctrlState stateNext;
    logic accept;
    logic isTimer;
    logic accessEnd;

    assign accept = reqValid && (state == stateIdle);

    // held request, only meaningful outside idle
    always_ff @(posedge clk) begin
        if (accept) begin
            req.reqWrite <= reqWrite;
            req.reqWidth <= reqWidth;
            req.reqAddr <= reqAddr;
            req.reqWdata <= reqWdata;
        end
    end

    assign isTimer = (req.reqAddr == platformPkg::mtimeAddr) ||
                     (req.reqAddr == platformPkg::mtimecmpAddr);

    // timer registers answer in one cycle and ignore the memory stall
    assign accessEnd = isTimer || !memStall;

    always_comb begin
        stateNext = state;
        case (state)
            stateIdle: begin
                if (accept) begin
                    stateNext = stateAccess;
                end
            end
            stateAccess: begin
                if (accessEnd) begin
                    stateNext = stateDone;
                end
            end
            default: begin
                stateNext = stateIdle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stateIdle;
        end else begin
            state <= stateNext;
        end
    end

    assign busy = (state != stateIdle);
    assign done = (state == stateDone);

    assign weMem = (state == stateAccess) && !isTimer && req.reqWrite;
    assign reMem = (state == stateAccess) && !isTimer && !req.reqWrite;

    assign req.captureLoad = (state == stateAccess) && !req.reqWrite && accessEnd;
    assign req.timerWrite = (state == stateAccess) && req.reqWrite && isTimer;

    strobeExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(weMem && reMem));

    donePulse: assert property (@(posedge clk) disable iff (!arstN)
        done |=> !done);

endmodule

`default_nettype wire

// File: verilog/storeFormatter.sv
`timescale 1ns/1ps
`default_nettype none

module storeFormatter (
    memReqIf.data req,
    output logic [rvMemPkg::xlen-1:0] wdataMem,
    output logic [rvMemPkg::maskWidth-1:0] wmaskMem
);

    rvMemPkg::memWord lanes;
    logic [2:0] offset;

    assign offset = req.reqAddr[2:0];

    always_comb begin
        lanes = '0;
        wmaskMem = '0;
        case (req.reqWidth)
            rvMemPkg::lb, rvMemPkg::lbu: begin
                lanes.bytes[offset] = req.reqWdata[7:0];
                wmaskMem[offset] = 1'b1;
            end
            rvMemPkg::lh, rvMemPkg::lhu: begin
                lanes.half[offset[2:1]] = req.reqWdata[15:0];
                wmaskMem[{offset[2:1], 1'b0} +: 2] = 2'b11;
            end
            rvMemPkg::lw, rvMemPkg::lwu: begin
                lanes.word[offset[2]] = req.reqWdata[31:0];
                wmaskMem[{offset[2], 2'b00} +: 4] = 4'hf;
            end
            default: begin
                lanes.dword = req.reqWdata;
                wmaskMem = '1;
            end
        endcase
        wdataMem = lanes;

        // a store must always touch at least one byte
        assert (!req.reqWrite || (wmaskMem != '0));
    end

endmodule

`default_nettype wire

// File: verilog/loadAligner.sv
`timescale 1ns/1ps
`default_nettype none

module loadAligner (
    input  logic clk,
    input  logic arstN,
    memReqIf.data req,
    input  logic [rvMemPkg::xlen-1:0] rdataMem,
    input  logic [rvMemPkg::xlen-1:0] timerData,
    output logic [rvMemPkg::xlen-1:0] rdData
);

    localparam int xlen = rvMemPkg::xlen;

    rvMemPkg::memWord src;
    logic [2:0] offset;
    logic isTimer;
    logic [xlen-1:0] loadValue;
    logic [7:0] byteLane;
    logic [15:0] halfLane;
    logic [31:0] wordLane;

    assign isTimer = (req.reqAddr == platformPkg::mtimeAddr) ||
                     (req.reqAddr == platformPkg::mtimecmpAddr);

    assign src = isTimer ? timerData : rdataMem;
    assign offset = req.reqAddr[2:0];

    // addressed lane of each size
    assign byteLane = src.bytes[offset];
    assign halfLane = src.half[offset[2:1]];
    assign wordLane = src.word[offset[2]];

    always_comb begin
        case (req.reqWidth)
            rvMemPkg::lb: begin
                loadValue = {{(xlen-8){byteLane[7]}}, byteLane};
            end
            rvMemPkg::lbu: begin
                loadValue = {{(xlen-8){1'b0}}, byteLane};
            end
            rvMemPkg::lh: begin
                loadValue = {{(xlen-16){halfLane[15]}}, halfLane};
            end
            rvMemPkg::lhu: begin
                loadValue = {{(xlen-16){1'b0}}, halfLane};
            end
            rvMemPkg::lw: begin
                loadValue = {{(xlen-32){wordLane[31]}}, wordLane};
            end
            rvMemPkg::lwu: begin
                loadValue = {{(xlen-32){1'b0}}, wordLane};
            end
            default: begin
                loadValue = src.dword;
            end
        endcase
    end

    // result stays put across stores and idle cycles
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdData <= '0;
        end else if (req.captureLoad) begin
            rdData <= loadValue;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mmioTimer.sv
`timescale 1ns/1ps
`default_nettype none

module mmioTimer #(
    parameter int unsigned TimerStep = 1
) (
    input  logic clk,
    input  logic arstN,
    memReqIf.data req,
    output logic [rvMemPkg::xlen-1:0] timerData,
    output logic timerIrq
);

    localparam int xlen = rvMemPkg::xlen;

    logic [xlen-1:0] mtime;
    logic [xlen-1:0] mtimecmp;
    logic hitMtime;
    logic hitMtimecmp;

    assign hitMtime = (req.reqAddr == platformPkg::mtimeAddr);
    assign hitMtimecmp = (req.reqAddr == platformPkg::mtimecmpAddr);

    // free running, a software write wins over the increment
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mtime <= '0;
        end else if (req.timerWrite && hitMtime) begin
            mtime <= req.reqWdata;
        end else begin
            mtime <= mtime + xlen'(TimerStep);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mtimecmp <= platformPkg::mtimecmpReset;
        end else if (req.timerWrite && hitMtimecmp) begin
            mtimecmp <= req.reqWdata;
        end
    end

    assign timerData = hitMtimecmp ? mtimecmp : mtime;

    // level interrupt, unsigned compare
    assign timerIrq = (mtime >= mtimecmp);

endmodule

`default_nettype wire

// File: verilog/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit #(
    parameter int unsigned TimerStep = 1
) (
    input  logic clk,
    input  logic arstN,
    input  logic reqValid,
    input  logic reqWrite,
    input  rvMemPkg::widthCode reqWidth,
    input  logic [rvMemPkg::xlen-1:0] reqAddr,
    input  logic [rvMemPkg::xlen-1:0] reqWdata,
    input  logic [rvMemPkg::xlen-1:0] rdataMem,
    input  logic memStall,
    output logic busy,
    output logic done,
    output logic [rvMemPkg::xlen-1:0] rdData,
    output logic [rvMemPkg::xlen-1:0] address,
    output logic weMem,
    output logic reMem,
    output logic [rvMemPkg::xlen-1:0] wdataMem,
    output logic [rvMemPkg::maskWidth-1:0] wmaskMem,
    output logic timerIrq
);

    memReqIf req ();

    logic [rvMemPkg::xlen-1:0] timerData;

    accessControl uAccessControl (
        .clk(clk),
        .arstN(arstN),
        .reqValid(reqValid),
        .reqWrite(reqWrite),
        .reqWidth(reqWidth),
        .reqAddr(reqAddr),
        .reqWdata(reqWdata),
        .memStall(memStall),
        .busy(busy),
        .done(done),
        .weMem(weMem),
        .reMem(reMem),
        .req(req.ctrl)
    );

    storeFormatter uStoreFormatter (
        .req(req.data),
        .wdataMem(wdataMem),
        .wmaskMem(wmaskMem)
    );

    loadAligner uLoadAligner (
        .clk(clk),
        .arstN(arstN),
        .req(req.data),
        .rdataMem(rdataMem),
        .timerData(timerData),
        .rdData(rdData)
    );

    mmioTimer #(
        .TimerStep(TimerStep)
    ) uMmioTimer (
        .clk(clk),
        .arstN(arstN),
        .req(req.data),
        .timerData(timerData),
        .timerIrq(timerIrq)
    );

    // memory sees the held address for the whole access
    assign address = req.reqAddr;

endmodule

`default_nettype wire

// File: dv/tbLoadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbLoadStoreUnit;

    localparam int numReqs = 400;
    localparam int maxStall = 6;
    localparam int clkPeriod = 8;

    localparam logic [63:0] ramBase = 64'h0000_0000_8000_0000;
    localparam logic [63:0] mtimeAddr = 64'h0000_0000_0200_bff8;
    localparam logic [63:0] mtimecmpAddr = 64'h0000_0000_0200_4000;
    localparam logic [63:0] mtimecmpReset = '1;

    logic clk, arstN, reqValid, reqWrite, memStall;
    rvMemPkg::widthCode reqWidth;
    logic [63:0] reqAddr, reqWdata, rdataMem;
    logic busy, done, weMem, reMem, timerIrq;
    logic [63:0] rdData, address, wdataMem;
    logic [7:0] wmaskMem;

    logic [31:0] lfsrState = 32'h97dd6b51;
    logic [63:0] ram [16];
    logic [63:0] refMem [16];
    logic [63:0] modelMtime;
    logic [63:0] modelMtimecmp;
    logic [63:0] timerWrData;
    logic timerWrMtime;
    logic timerWrCmp;

    loadStoreUnit dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [63:0] randBits(input int count);
        logic [63:0] value;
        logic fb;
        value = '0;
        repeat (count) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            value = {value[62:0], fb};
        end
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] laneMask(input logic [2:0] offset, input int nBytes);
        int m;
        m = ((1 << nBytes) - 1) << offset;
        return m[7:0];
    endfunction

    function automatic logic [63:0] expandMask(input logic [7:0] mask);
        logic [63:0] bits;
        logic [7:0] m;
        bits = '0;
        m = mask;
        repeat (8) begin
            bits = {{8{m[0]}}, bits[63:8]};
            m = m >> 1;
        end
        return bits;
    endfunction

    function automatic logic [63:0] loadExpect(input logic [63:0] word, input logic [2:0] offset,
                                               input logic [2:0] width);
        logic [63:0] value;
        logic [63:0] keep;
        keep = expandMask(laneMask(3'd0, 1 << width[1:0]));
        value = (word >> {offset, 3'b000}) & keep;
        // signed loads copy the top loaded bit upward
        if (!width[2] && ((value & keep & ~(keep >> 1)) != 64'd0)) begin
            value = value | ~keep;
        end
        return value;
    endfunction

    // timer model, fed by the store flags set in the access cycle
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            modelMtime <= '0;
            modelMtimecmp <= mtimecmpReset;
        end else begin
            modelMtime <= timerWrMtime ? timerWrData : modelMtime + 64'd1;
            if (timerWrCmp) begin
                modelMtimecmp <= timerWrData;
            end
        end
    end

    always @(negedge clk) begin
        if (arstN) begin
            checkValue("timerIrq", 64'(timerIrq), 64'(modelMtime >= modelMtimecmp));
        end
    end

    task automatic runRequest();
        logic isTimer;
        logic ended;
        logic [3:0] index;
        logic [2:0] offset;
        logic [7:0] mask;
        logic [63:0] laneData;
        logic [63:0] expectRd;
        int stalls;

        reqWrite = 1'(randBits(1));
        isTimer = (randBits(3) == 64'd0);
        index = 4'(randBits(4));
        if (isTimer) begin
            reqWidth = rvMemPkg::ld;
            reqAddr = (randBits(1) == 64'd1) ? mtimecmpAddr : mtimeAddr;
            // near the current time, so the interrupt moves both ways
            reqWdata = modelMtime + randBits(8) - 64'd128;
        end else begin
            reqWidth = 3'(randBits(2));
            if (!reqWrite && reqWidth != rvMemPkg::ld) begin
                reqWidth[2] = 1'(randBits(1));
            end
            offset = 3'(randBits(3)) & 3'(~((1 << reqWidth[1:0]) - 1));
            reqAddr = ramBase + {57'd0, index, offset};
            reqWdata = randBits(64);
        end
        reqValid = 1'b1;
        memStall = 1'(randBits(1));
        @(negedge clk);

        reqValid = 1'b0;
        mask = laneMask(reqAddr[2:0], 1 << reqWidth[1:0]);
        laneData = (reqWdata << {reqAddr[2:0], 3'b000}) & expandMask(mask);
        expectRd = rdData;
        stalls = 0;
        ended = 1'b0;
        while (!ended) begin
            checkValue("busy", 64'(busy), 64'd1);
            checkValue("done", 64'(done), 64'd0);
            checkValue("address", address, reqAddr);
            checkValue("weMem", 64'(weMem), 64'(reqWrite && !isTimer));
            checkValue("reMem", 64'(reMem), 64'(!reqWrite && !isTimer));
            if (reqWrite) begin
                checkValue("wmaskMem", 64'(wmaskMem), 64'(mask));
                checkValue("wdataMem", wdataMem & expandMask(mask), laneData);
            end
            rdataMem = reMem ? ram[address[6:3]] : randBits(64);
            memStall = (stalls < maxStall) ? 1'(randBits(1)) : 1'b0;
            ended = isTimer || !memStall;
            stalls++;
            if (ended) begin
                if (weMem) begin
                    ram[address[6:3]] = (ram[address[6:3]] & ~expandMask(wmaskMem)) |
                                        (wdataMem & expandMask(wmaskMem));
                end
                if (reqWrite && !isTimer) begin
                    refMem[index] = (refMem[index] & ~expandMask(mask)) | laneData;
                end
                if (!reqWrite && isTimer) begin
                    expectRd = (reqAddr == mtimecmpAddr) ? modelMtimecmp : modelMtime;
                end else if (!reqWrite) begin
                    expectRd = loadExpect(refMem[index], reqAddr[2:0], reqWidth);
                end
                timerWrMtime = isTimer && reqWrite && (reqAddr == mtimeAddr);
                timerWrCmp = isTimer && reqWrite && (reqAddr == mtimecmpAddr);
                timerWrData = reqWdata;
            end
            @(negedge clk);
            timerWrMtime = 1'b0;
            timerWrCmp = 1'b0;
        end

        checkValue("done", 64'(done), 64'd1);
        checkValue("busy", 64'(busy), 64'd1);
        checkValue("weMem", 64'(weMem), 64'd0);
        checkValue("reMem", 64'(reMem), 64'd0);
        checkValue("rdData", rdData, expectRd);
        @(negedge clk);
        checkValue("busy", 64'(busy), 64'd0);
        checkValue("done", 64'(done), 64'd0);
    endtask

    initial begin
        arstN = 1'b0;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqWidth = rvMemPkg::ld;
        reqAddr = '0;
        reqWdata = '0;
        rdataMem = '0;
        memStall = 1'b0;
        timerWrMtime = 1'b0;
        timerWrCmp = 1'b0;
        timerWrData = '0;
        for (int i = 0; i < 16; i++) begin
            ram[4'(i)] = (ramBase + 64'(8 * i)) * 64'h9e37_79b9_7f4a_7c15;
            refMem[4'(i)] = ram[4'(i)];
        end
        repeat (5) @(negedge clk);
        checkValue("busy", 64'(busy), 64'd0);
        checkValue("done", 64'(done), 64'd0);
        checkValue("weMem", 64'(weMem), 64'd0);
        checkValue("reMem", 64'(reMem), 64'd0);
        checkValue("timerIrq", 64'(timerIrq), 64'd0);
        arstN = 1'b1;
        @(negedge clk);
        checkValue("busy", 64'(busy), 64'd0);
        checkValue("timerIrq", 64'(timerIrq), 64'd0);
        repeat (numReqs) runRequest();
        $display("No errors");
        $finish;
    end

    // each request needs at most maxStall + 3 cycles
    initial begin
        #((numReqs * (maxStall + 4) + 20) * clkPeriod);
        $display("timeout: the DUT stopped answering before all requests finished");
        $display("Errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP := tbLoadStoreUnit
FILELIST := tb.f
OBJDIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# a failing run leaves through $fatal, so make sees a nonzero status
run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: tb.f
verilog/rvMemPkg.sv
verilog/platformPkg.sv
verilog/memReqIf.sv
verilog/accessControl.sv
verilog/storeFormatter.sv
verilog/loadAligner.sv
verilog/mmioTimer.sv
verilog/loadStoreUnit.sv
dv/tbLoadStoreUnit.sv
